// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dcache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// File: sim/tb_dcache.sv
module tb_dcache
    import dcache_pkg::*;
();

    localparam int N_SETS       = 64;
    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED   = 17;
    localparam int N_RANDOM     = 300;
    // 20 cycles per request leaves room for a writeback and a refill
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + RESET_CYCLES;

    logic       clk;
    logic       rst;
    logic       req_i;
    addr_t      addr_i;
    strb_t      wstrb_i;
    word_t      wdata_i;
    logic       uncached_i;
    logic       ready_o;
    logic       data_ok_o;
    word_t      rdata_o;
    logic       mem_req_o;
    logic       mem_we_o;
    logic       mem_uncached_o;
    addr_t      mem_addr_o;
    line_t      mem_wdata_o;
    line_strb_t mem_wstrb_o;
    logic       mem_ack_i;
    line_t      mem_rdata_i;

    // word addressed 16 KB backing store and its expected image
    word_t mem_store [4096];
    word_t ref_mem [4096];

    integer seed;
    int     error_count = 0;
    int     n_requests = 0;
    int     loads_checked = 0;
    int     wb_checked = 0;
    int     cycle_count = 0;
    int     mem_req_count = 0;

    logic       mm_busy;
    int         mm_delay;
    int         mm_rnd;
    logic       mm_we;
    addr_t      mm_addr;
    line_t      mm_wdata;
    line_strb_t mm_wstrb;

    logic         outstanding;
    logic         started;
    logic         drive_hit;
    logic         last_cached;
    logic [27:0]  last_line;
    addr_t        cur_addr;
    logic         cur_store;
    logic         cur_uc;
    word_t        cur_exp;
    line_strb_t   exp_uc_strb;
    line_t        exp_wb_line;

    dcache_top #(
        .N_SETS(N_SETS)
    ) u_dcache_top (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .wstrb_i       (wstrb_i),
        .wdata_i       (wdata_i),
        .uncached_i    (uncached_i),
        .ready_o       (ready_o),
        .data_ok_o     (data_ok_o),
        .rdata_o       (rdata_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_uncached_o(mem_uncached_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .mem_ack_i     (mem_ack_i),
        .mem_rdata_i   (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory fill is a hash of the word address
    function automatic word_t fill_word(input logic [11:0] widx);
        word_t a;
        a = {18'd0, widx, 2'b00};
        return (a * 32'h9e37_79b1) ^ 32'h6a09_e667;
    endfunction

    // expected line at the writeback address
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            exp_wb_line[32*w +: 32] = ref_mem[{mem_addr_o[13:4], 2'(w)}];
        end
    end

    task automatic serve_request();
        logic [9:0]  line_idx;
        logic [11:0] widx;
        line_idx = mm_addr[13:4];
        for (int b = 0; b < LINE_BYTES; b++) begin
            widx = {line_idx, 2'(b / 4)};
            if (mm_we && mm_wstrb[b]) begin
                mem_store[widx][8*(b%4) +: 8] = mm_wdata[8*b +: 8];
            end
        end
        for (int w = 0; w < 4; w++) begin
            mem_rdata_i[32*w +: 32] = mem_store[{line_idx, 2'(w)}];
        end
        mem_ack_i = 1'b1;
    endtask

    // memory model that answers each request after 1 to 4 cycles
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem_store[i] = fill_word(12'(i));
        end
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        mm_busy     = 1'b0;
        mm_delay    = 0;
        forever begin
            @(negedge clk);
            mem_ack_i = 1'b0;
            if (mm_busy) begin
                mm_delay = mm_delay - 1;
                if (mm_delay == 0) begin
                    serve_request();
                    mm_busy = 1'b0;
                end
            end
            if (mem_req_o && !rst) begin
                mm_rnd   = $random(seed);
                mm_delay = 1 + (mm_rnd & 3);
                mm_we    = mem_we_o;
                mm_addr  = mem_addr_o;
                mm_wdata = mem_wdata_o;
                mm_wstrb = mem_wstrb_o;
                mm_busy  = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            outstanding   <= 1'b0;
            started       <= 1'b0;
            mem_req_count <= 0;
        end else begin
            if (req_i && ready_o) begin
                outstanding   <= 1'b1;
                started       <= 1'b1;
                mem_req_count <= 0;
            end else begin
                if (data_ok_o) begin
                    outstanding <= 1'b0;
                end
                if (mem_req_o) begin
                    mem_req_count <= mem_req_count + 1;
                end
            end
            if (data_ok_o && !cur_store) begin
                loads_checked <= loads_checked + 1;
            end
            if (mem_req_o && mem_we_o && !mem_uncached_o) begin
                wb_checked <= wb_checked + 1;
            end
        end
    end

    reset_idle: assert property (@(posedge clk) disable iff (rst)
        !started |-> ready_o && !mem_req_o && !data_ok_o)
    else begin
        error_count++;
        $display("%0t: cache not idle after reset", $time);
    end

    load_data: assert property (@(posedge clk) disable iff (rst)
        data_ok_o && !cur_store |-> rdata_o == cur_exp)
    else begin
        error_count++;
        $display("FAILED %0t rdata_o: got %h, expected %h",
                 $time, $sampled(rdata_o), $sampled(cur_exp));
    end

    hit_latency: assert property (@(posedge clk) disable iff (rst)
        req_i && ready_o && drive_hit |=> data_ok_o && !mem_req_o)
    else begin
        error_count++;
        $display("%0t: hit on the previous line did not finish in one cycle", $time);
    end

    wb_data: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && mem_we_o && !mem_uncached_o |-> mem_wdata_o == exp_wb_line)
    else begin
        error_count++;
        $display("FAILED %0t mem_wdata_o: got %h, expected %h",
                 $time, $sampled(mem_wdata_o), $sampled(exp_wb_line));
    end

    uc_flag: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> mem_uncached_o == cur_uc)
    else begin
        error_count++;
        $display("FAILED %0t mem_uncached_o: got %b, expected %b",
                 $time, $sampled(mem_uncached_o), $sampled(cur_uc));
    end

    uc_addr: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && mem_uncached_o |-> mem_addr_o == cur_addr)
    else begin
        error_count++;
        $display("FAILED %0t mem_addr_o: got %h, expected %h",
                 $time, $sampled(mem_addr_o), $sampled(cur_addr));
    end

    uc_we: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && cur_uc |-> mem_we_o == cur_store)
    else begin
        error_count++;
        $display("FAILED %0t mem_we_o: got %b, expected %b",
                 $time, $sampled(mem_we_o), $sampled(cur_store));
    end

    uc_strb: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && mem_uncached_o && cur_store |-> mem_wstrb_o == exp_uc_strb)
    else begin
        error_count++;
        $display("FAILED %0t mem_wstrb_o: got %h, expected %h",
                 $time, $sampled(mem_wstrb_o), $sampled(exp_uc_strb));
    end

    uc_count: assert property (@(posedge clk) disable iff (rst)
        data_ok_o && cur_uc |-> mem_req_count == 1)
    else begin
        error_count++;
        $display("%0t: uncached access did not issue exactly one memory request", $time);
    end

    one_ack: assert property (@(posedge clk) disable iff (rst)
        data_ok_o |-> outstanding && !ready_o)
    else begin
        error_count++;
        $display("%0t: data_ok_o without an outstanding request", $time);
    end

    mem_overlap: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> !$past(mm_busy))
    else begin
        error_count++;
        $display("%0t: memory request while another one is pending", $time);
    end

    task automatic issue_request(input addr_t addr, input strb_t strb, input word_t data,
                                 input logic uc);
        logic [11:0] widx;
        widx = addr[13:2];
        while (!ready_o) begin
            @(negedge clk);
        end
        drive_hit   = !uc && last_cached && (addr[31:4] == last_line);
        cur_addr    = addr;
        cur_store   = |strb;
        cur_uc      = uc;
        cur_exp     = ref_mem[widx];
        exp_uc_strb = '0;
        exp_uc_strb[4*addr[3:2] +: 4] = strb;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                ref_mem[widx][8*b +: 8] = data[8*b +: 8];
            end
        end
        req_i      = 1'b1;
        addr_i     = addr;
        wstrb_i    = strb;
        wdata_i    = data;
        uncached_i = uc;
        @(negedge clk);
        req_i     = 1'b0;
        drive_hit = 1'b0;
        while (outstanding) begin
            @(negedge clk);
        end
        last_cached = !uc;
        last_line   = addr[31:4];
        n_requests++;
    endtask

    task automatic random_request();
        int    r;
        addr_t a;
        strb_t s;
        word_t d;
        logic  uc;
        r  = $random(seed);
        d  = $random(seed);
        uc = (r[2:0] == 3'd0);
        a  = '0;
        if (uc) begin
            a[13:12] = 2'b11;
            a[7:2]   = r[13:8];
        end else begin
            // eight tags over four sets
            a[12:10] = r[10:8];
            a[5:4]   = r[12:11];
            a[3:2]   = r[14:13];
            if (r[16:15] == 2'b00 && last_cached) begin
                a[31:4] = last_line;
            end
        end
        if (!r[3]) begin
            s = 4'b0000;
        end else if (r[5:4] == 2'b00) begin
            s      = 4'b0001 << r[7:6];
            a[1:0] = r[7:6];
        end else if (r[5:4] == 2'b01) begin
            s      = r[6] ? 4'b1100 : 4'b0011;
            a[1:0] = {r[6], 1'b0};
        end else begin
            s = 4'b1111;
        end
        issue_request(a, s, d, uc);
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a request never completed", cycle_count);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed        = 32'he398;
        rst         = 1'b1;
        req_i       = 1'b0;
        addr_i      = '0;
        wstrb_i     = '0;
        wdata_i     = '0;
        uncached_i  = 1'b0;
        drive_hit   = 1'b0;
        last_cached = 1'b0;
        last_line   = '0;
        cur_addr    = '0;
        cur_store   = 1'b0;
        cur_uc      = 1'b0;
        cur_exp     = '0;
        exp_uc_strb = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = fill_word(12'(i));
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // clean miss then hits with byte and half stores
        issue_request(32'h0000_0100, 4'b0000, 32'h0, 1'b0);
        issue_request(32'h0000_0104, 4'b0000, 32'h0, 1'b0);
        issue_request(32'h0000_0101, 4'b0010, 32'h0000_ab00, 1'b0);
        issue_request(32'h0000_010a, 4'b1100, 32'h1234_0000, 1'b0);
        issue_request(32'h0000_0100, 4'b0000, 32'h0, 1'b0);
        issue_request(32'h0000_0108, 4'b0000, 32'h0, 1'b0);

        // three tags in set 0x20 force a dirty eviction
        issue_request(32'h0000_0200, 4'b1111, 32'hdead_0200, 1'b0);
        issue_request(32'h0000_0600, 4'b1111, 32'hdead_0600, 1'b0);
        issue_request(32'h0000_0a00, 4'b1111, 32'hdead_0a00, 1'b0);
        issue_request(32'h0000_0200, 4'b0000, 32'h0, 1'b0);
        issue_request(32'h0000_0600, 4'b0000, 32'h0, 1'b0);
        issue_request(32'h0000_0a00, 4'b0000, 32'h0, 1'b0);

        issue_request(32'h0000_3006, 4'b1100, 32'h5a5a_0000, 1'b1);
        issue_request(32'h0000_3004, 4'b0000, 32'h0, 1'b1);
        issue_request(32'h0000_3010, 4'b0000, 32'h0, 1'b1);

        // store miss merged into the refill
        issue_request(32'h0000_1203, 4'b1000, 32'h7700_0000, 1'b0);
        issue_request(32'h0000_1200, 4'b0000, 32'h0, 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            random_request();
        end

        repeat (4) @(negedge clk);
        $display("errors: %0d, requests: %0d, loads checked: %0d, writebacks checked: %0d",
                 error_count, n_requests, loads_checked, wb_checked);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/cache_way_ram.sv
module cache_way_ram
    import dcache_pkg::*;
#(
    parameter int N_SETS = 64,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rd_en_i,
    input  logic [IDX_W-1:0] rd_index_i,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_index_i,
    input  logic [TAG_W-1:0] wr_tag_i,
    input  logic             wr_dirty_i,
    input  line_strb_t       wr_byte_en_i,
    input  line_t            wr_line_i,
    output logic             rd_valid_o,
    output logic             rd_dirty_o,
    output logic [TAG_W-1:0] rd_tag_o,
    output line_t            rd_line_o
);

    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_mem;
    logic [TAG_W-1:0]  tag_mem [N_SETS];
    line_t             data_mem [N_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            dirty_mem[wr_index_i] <= wr_dirty_i;
            tag_mem[wr_index_i]   <= wr_tag_i;
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_byte_en_i[b]) begin
                    data_mem[wr_index_i][b*BYTE_W +: BYTE_W] <= wr_line_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // read port outputs hold their value while rd_en_i is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_valid_o <= valid_q[rd_index_i];
            rd_dirty_o <= dirty_mem[rd_index_i];
            rd_tag_o   <= tag_mem[rd_index_i];
            rd_line_o  <= data_mem[rd_index_i];
        end
    end

endmodule

// File: verilog/dcache_ctrl.sv
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int N_SETS = 64,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W
) (
    input  logic                  clk,
    input  logic                  rst,
    // core side
    input  logic                  req_i,
    input  addr_t                 addr_i,
    input  strb_t                 wstrb_i,
    input  word_t                 wdata_i,
    input  logic                  uncached_i,
    output logic                  ready_o,
    output logic                  data_ok_o,
    output word_t                 rdata_o,
    // memory side
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output logic                  mem_uncached_o,
    output addr_t                 mem_addr_o,
    output line_t                 mem_wdata_o,
    output line_strb_t            mem_wstrb_o,
    input  logic                  mem_ack_i,
    input  line_t                 mem_rdata_i,
    // way rams
    output logic                  rd_en_o,
    output logic [IDX_W-1:0]      rd_index_o,
    output logic [N_WAYS-1:0]     wr_en_o,
    output logic [IDX_W-1:0]      wr_index_o,
    output logic [TAG_W-1:0]      wr_tag_o,
    output logic                  wr_dirty_o,
    output line_strb_t            wr_byte_en_o,
    output line_t                 wr_line_o,
    input  logic                  way0_rd_valid_i,
    input  logic                  way0_rd_dirty_i,
    input  logic [TAG_W-1:0]      way0_rd_tag_i,
    input  line_t                 way0_rd_line_i,
    input  logic                  way1_rd_valid_i,
    input  logic                  way1_rd_dirty_i,
    input  logic [TAG_W-1:0]      way1_rd_tag_i,
    input  line_t                 way1_rd_line_i,
    // store merger
    output line_t                 merge_base_o,
    output logic [WORD_OFF_W-1:0] merge_offset_o,
    output strb_t                 merge_wstrb_o,
    output word_t                 merge_wdata_o,
    input  line_t                 merged_line_i
);

    localparam logic [15:0] LFSR_SEED = 16'hace1;

    ctrl_state_e state, next_state;

    addr_t req_addr_q;
    strb_t req_wstrb_q;
    word_t req_wdata_q;
    logic  req_uc_q;
    logic  victim_q;
    logic [15:0] lfsr_q;

    logic [TAG_W-1:0]      req_tag;
    logic [IDX_W-1:0]      req_idx;
    logic [WORD_OFF_W-1:0] req_word;
    logic                  is_store;
    logic [N_WAYS-1:0]     way_hit;
    line_t                 hit_line;
    logic                  miss_way;
    logic                  victim_dirty;
    logic [TAG_W-1:0]      victim_tag;
    line_t                 victim_line;
    line_strb_t            word_strb;

    assign req_tag  = req_addr_q[ADDR_W-1 -: TAG_W];
    assign req_idx  = req_addr_q[OFFSET_W +: IDX_W];
    assign req_word = req_addr_q[WORD_LSB +: WORD_OFF_W];
    assign is_store = |req_wstrb_q;

    assign way_hit[0] = way0_rd_valid_i && (way0_rd_tag_i == req_tag);
    assign way_hit[1] = way1_rd_valid_i && (way1_rd_tag_i == req_tag);
    assign hit_line   = way_hit[1] ? way1_rd_line_i : way0_rd_line_i;

    // victim way is the lfsr bit at the miss, registered for the later states
    assign miss_way     = lfsr_q[0];
    assign victim_dirty = miss_way ? (way1_rd_valid_i && way1_rd_dirty_i)
                                   : (way0_rd_valid_i && way0_rd_dirty_i);
    assign victim_tag   = victim_q ? way1_rd_tag_i : way0_rd_tag_i;
    assign victim_line  = victim_q ? way1_rd_line_i : way0_rd_line_i;

    assign word_strb = line_strb_t'(req_wstrb_q) << {req_word, 2'b00};

    assign merge_base_o   = (state == LOOKUP) ? hit_line : mem_rdata_i;
    assign merge_offset_o = req_word;
    assign merge_wstrb_o  = req_wstrb_q;
    assign merge_wdata_o  = req_wdata_q;

    assign ready_o    = (state == IDLE);
    assign rd_en_o    = (state == IDLE) && req_i && !uncached_i;
    assign rd_index_o = addr_i[OFFSET_W +: IDX_W];
    assign rdata_o    = (state == LOOKUP) ? hit_line[req_word*WORD_W +: WORD_W]
                                          : mem_rdata_i[req_word*WORD_W +: WORD_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            lfsr_q <= LFSR_SEED;
        end else begin
            state  <= next_state;
            lfsr_q <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            req_addr_q  <= addr_i;
            req_wstrb_q <= wstrb_i;
            req_wdata_q <= wdata_i;
            req_uc_q    <= uncached_i;
        end
        if (state == LOOKUP) begin
            victim_q <= miss_way;
        end
    end

    always_comb begin
        next_state     = state;
        data_ok_o      = 1'b0;
        mem_req_o      = 1'b0;
        mem_we_o       = 1'b0;
        mem_uncached_o = 1'b0;
        mem_addr_o     = {req_tag, req_idx, {OFFSET_W{1'b0}}};
        mem_wdata_o    = victim_line;
        mem_wstrb_o    = '1;
        wr_en_o        = '0;
        wr_index_o     = req_idx;
        wr_tag_o       = req_tag;
        wr_dirty_o     = 1'b1;
        wr_byte_en_o   = word_strb;
        wr_line_o      = merged_line_i;

        case (state)
            IDLE: begin
                if (req_i) begin
                    next_state = uncached_i ? UC_REQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (|way_hit) begin
                    data_ok_o  = 1'b1;
                    wr_en_o    = is_store ? way_hit : '0;
                    next_state = IDLE;
                end else if (victim_dirty) begin
                    next_state = WB_REQ;
                end else begin
                    next_state = FILL_REQ;
                end
            end
            WB_REQ: begin
                mem_req_o  = 1'b1;
                mem_we_o   = 1'b1;
                mem_addr_o = {victim_tag, req_idx, {OFFSET_W{1'b0}}};
                next_state = WB_WAIT;
            end
            WB_WAIT: begin
                if (mem_ack_i) begin
                    next_state = FILL_REQ;
                end
            end
            FILL_REQ: begin
                mem_req_o  = 1'b1;
                next_state = FILL_WAIT;
            end
            FILL_WAIT: begin
                // refill line with a missing store merged in
                wr_dirty_o   = is_store;
                wr_byte_en_o = '1;
                if (mem_ack_i) begin
                    wr_en_o[victim_q] = 1'b1;
                    data_ok_o         = 1'b1;
                    next_state        = IDLE;
                end
            end
            UC_REQ: begin
                mem_req_o      = 1'b1;
                mem_we_o       = is_store;
                mem_uncached_o = req_uc_q;
                mem_addr_o     = req_addr_q;
                mem_wdata_o    = {(LINE_W / WORD_W){req_wdata_q}};
                mem_wstrb_o    = word_strb;
                next_state     = UC_WAIT;
            end
            UC_WAIT: begin
                if (mem_ack_i) begin
                    data_ok_o  = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

// File: verilog/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BYTE_W     = 8;
    localparam int LINE_BYTES = 16;
    localparam int LINE_W     = LINE_BYTES * BYTE_W;
    localparam int STRB_W     = WORD_W / BYTE_W;

    // byte offset in the line and the word index inside it
    localparam int OFFSET_W   = 4;
    localparam int WORD_LSB   = 2;
    localparam int WORD_OFF_W = OFFSET_W - WORD_LSB;

    // replacement uses a single lfsr bit, so this stays at two
    localparam int N_WAYS = 2;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        UC_REQ,
        UC_WAIT
    } ctrl_state_e;

endpackage

// File: verilog/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
#(
    parameter int N_SETS = 64,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    input  addr_t      addr_i,
    input  strb_t      wstrb_i,
    input  word_t      wdata_i,
    input  logic       uncached_i,
    output logic       ready_o,
    output logic       data_ok_o,
    output word_t      rdata_o,
    output logic       mem_req_o,
    output logic       mem_we_o,
    output logic       mem_uncached_o,
    output addr_t      mem_addr_o,
    output line_t      mem_wdata_o,
    output line_strb_t mem_wstrb_o,
    input  logic       mem_ack_i,
    input  line_t      mem_rdata_i
);

    logic                  rd_en;
    logic [IDX_W-1:0]      rd_index;
    logic [N_WAYS-1:0]     wr_en;
    logic [IDX_W-1:0]      wr_index;
    logic [TAG_W-1:0]      wr_tag;
    logic                  wr_dirty;
    line_strb_t            wr_byte_en;
    line_t                 wr_line;

    logic                  way0_valid, way1_valid;
    logic                  way0_dirty, way1_dirty;
    logic [TAG_W-1:0]      way0_tag, way1_tag;
    line_t                 way0_line, way1_line;

    line_t                 merge_base;
    logic [WORD_OFF_W-1:0] merge_offset;
    strb_t                 merge_wstrb;
    word_t                 merge_wdata;
    line_t                 merged_line;

    dcache_ctrl #(
        .N_SETS(N_SETS)
    ) u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .addr_i         (addr_i),
        .wstrb_i        (wstrb_i),
        .wdata_i        (wdata_i),
        .uncached_i     (uncached_i),
        .ready_o        (ready_o),
        .data_ok_o      (data_ok_o),
        .rdata_o        (rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_uncached_o (mem_uncached_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_wstrb_o    (mem_wstrb_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i),
        .rd_en_o        (rd_en),
        .rd_index_o     (rd_index),
        .wr_en_o        (wr_en),
        .wr_index_o     (wr_index),
        .wr_tag_o       (wr_tag),
        .wr_dirty_o     (wr_dirty),
        .wr_byte_en_o   (wr_byte_en),
        .wr_line_o      (wr_line),
        .way0_rd_valid_i(way0_valid),
        .way0_rd_dirty_i(way0_dirty),
        .way0_rd_tag_i  (way0_tag),
        .way0_rd_line_i (way0_line),
        .way1_rd_valid_i(way1_valid),
        .way1_rd_dirty_i(way1_dirty),
        .way1_rd_tag_i  (way1_tag),
        .way1_rd_line_i (way1_line),
        .merge_base_o   (merge_base),
        .merge_offset_o (merge_offset),
        .merge_wstrb_o  (merge_wstrb),
        .merge_wdata_o  (merge_wdata),
        .merged_line_i  (merged_line)
    );

    cache_way_ram #(
        .N_SETS(N_SETS)
    ) u_way0 (
        .clk         (clk),
        .rst         (rst),
        .rd_en_i     (rd_en),
        .rd_index_i  (rd_index),
        .wr_en_i     (wr_en[0]),
        .wr_index_i  (wr_index),
        .wr_tag_i    (wr_tag),
        .wr_dirty_i  (wr_dirty),
        .wr_byte_en_i(wr_byte_en),
        .wr_line_i   (wr_line),
        .rd_valid_o  (way0_valid),
        .rd_dirty_o  (way0_dirty),
        .rd_tag_o    (way0_tag),
        .rd_line_o   (way0_line)
    );

    cache_way_ram #(
        .N_SETS(N_SETS)
    ) u_way1 (
        .clk         (clk),
        .rst         (rst),
        .rd_en_i     (rd_en),
        .rd_index_i  (rd_index),
        .wr_en_i     (wr_en[1]),
        .wr_index_i  (wr_index),
        .wr_tag_i    (wr_tag),
        .wr_dirty_i  (wr_dirty),
        .wr_byte_en_i(wr_byte_en),
        .wr_line_i   (wr_line),
        .rd_valid_o  (way1_valid),
        .rd_dirty_o  (way1_dirty),
        .rd_tag_o    (way1_tag),
        .rd_line_o   (way1_line)
    );

    store_merge u_merge (
        .base_line_i  (merge_base),
        .offset_i     (merge_offset),
        .wstrb_i      (merge_wstrb),
        .wdata_i      (merge_wdata),
        .merged_line_o(merged_line)
    );

endmodule

// File: verilog/store_merge.sv
module store_merge
    import dcache_pkg::*;
(
    input  line_t                 base_line_i,
    input  logic [WORD_OFF_W-1:0] offset_i,
    input  strb_t                 wstrb_i,
    input  word_t                 wdata_i,
    output line_t                 merged_line_o
);

    word_t base_word;
    word_t merged_word;

    // pick out the addressed word of the line
    always_comb begin
        base_word = base_line_i[offset_i*WORD_W +: WORD_W];
    end

    // strobed bytes come from the store, the rest from the line
    always_comb begin
        merged_word = base_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) begin
                merged_word[b*BYTE_W +: BYTE_W] = wdata_i[b*BYTE_W +: BYTE_W];
            end
        end
    end

    always_comb begin
        merged_line_o = base_line_i;
        merged_line_o[offset_i*WORD_W +: WORD_W] = merged_word;
    end

endmodule

// File: vlog.f
verilog/dcache_pkg.sv
verilog/cache_way_ram.sv
verilog/store_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/tb_dcache.sv
